//--- rtl/riscv_config.svh
// width, register count and data memory depth for the back end

`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// data path and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// data memory depth in 32-bit words
// addresses wrap modulo this depth
`define RV_DMEM_WORDS 256

`endif

//--- rtl/riscv_pkg.sv
// operation enums and pipeline stage structs for the back end
`include "riscv_config.svh"

package riscv_pkg;

    typedef logic [`RV_XLEN-1:0] xlen_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

    typedef enum logic [1:0] {
        OPER1_RS1,
        OPER1_PC,
        OPER1_ZERO
    } oper1_src_t;

    // OPER2_PC_INC is the constant 4 for link addresses
    typedef enum logic [1:0] {
        OPER2_RS2,
        OPER2_IMM,
        OPER2_PC_INC
    } oper2_src_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB,
        ALU_SEQ, ALU_SNEQ,
        ALU_SLT, ALU_SGE,
        ALU_SLTU, ALU_SGEU,
        ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA
    } alu_oper_t;

    typedef enum logic [1:0] {
        BNJ_NONE,
        BNJ_JAL,
        BNJ_JALR,
        BNJ_BRANCH
    } bnj_oper_t;

    // MEM_NOP must stay at zero so a cleared stage is a bubble
    typedef enum logic [2:0] {
        MEM_NOP,
        MEM_LW,
        MEM_LB,
        MEM_LBU,
        MEM_SW,
        MEM_SB
    } mem_oper_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_t;

    // decoded micro-op from the front end
    typedef struct packed {
        xlen_t      pc;
        reg_addr_t  rs1_addr;
        reg_addr_t  rs2_addr;
        reg_addr_t  rd_addr;
        xlen_t      imm;
        oper1_src_t oper1_src;
        oper2_src_t oper2_src;
        alu_oper_t  alu_oper;
        bnj_oper_t  bnj_oper;
        mem_oper_t  mem_oper;
        logic       write_rd;
        logic       wb_use_mem;
    } issue_t;

    typedef struct packed {
        issue_t uop;
        xlen_t  rs1_data;
        xlen_t  rs2_data;
        logic   valid;
    } id_ex_t;

    typedef struct packed {
        xlen_t     alu_result;
        xlen_t     store_data;
        mem_oper_t mem_oper;
        logic      wb_use_mem;
        logic      write_rd;
        reg_addr_t rd_addr;
    } ex_mem_t;

    typedef struct packed {
        xlen_t     result;
        logic      write_rd;
        reg_addr_t rd_addr;
    } mem_wb_t;

    typedef struct packed {
        logic  load_pc;
        xlen_t new_pc;
    } redirect_t;

endpackage

//--- rtl/id_ex_stage.sv
// register file with write-through and the ID/EX pipeline register
`include "riscv_config.svh"

module id_ex_stage
(
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               issue_valid_i,
    input  riscv_pkg::issue_t  issue_i,
    input  logic               flush_i,
    input  riscv_pkg::mem_wb_t wb_i,
    output riscv_pkg::id_ex_t  id_ex_o
);

    import riscv_pkg::*;

    xlen_t regs [`RV_NREGS];
    xlen_t rs1_data;
    xlen_t rs2_data;
    logic  wb_we;

    assign wb_we = wb_i.write_rd && (wb_i.rd_addr != '0);

    // x0 is never written and keeps its reset value
    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] <= '0;
        end
        else if (wb_we)
        begin
            regs[wb_i.rd_addr] <= wb_i.result;
        end
    end

    // same-cycle write passes straight to the reader
    function automatic xlen_t read_reg(reg_addr_t addr);
        xlen_t data;
        if (wb_we && (wb_i.rd_addr == addr))
            data = wb_i.result;
        else
            data = regs[addr];
        return data;
    endfunction

    always_comb
    begin
        rs1_data = read_reg(issue_i.rs1_addr);
        rs2_data = read_reg(issue_i.rs2_addr);
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            id_ex_o <= '0;
        end
        else
        begin
            id_ex_o.uop      <= issue_i;
            id_ex_o.rs1_data <= rs1_data;
            id_ex_o.rs2_data <= rs2_data;
            // squashed by a redirect, or no strobe at all
            id_ex_o.valid    <= issue_valid_i && !flush_i;
        end
    end

    x0_reads_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ((id_ex_o.uop.rs1_addr != '0) || (id_ex_o.rs1_data == '0)) &&
        ((id_ex_o.uop.rs2_addr != '0) || (id_ex_o.rs2_data == '0)))
        else $error("x0 captured with a nonzero value");

endmodule

//--- rtl/forward_unit.sv
// forwarding select logic for the two execute operands
module forward_unit
(
    input  riscv_pkg::id_ex_t   id_ex_i,
    input  riscv_pkg::ex_mem_t  ex_mem_i,
    input  riscv_pkg::mem_wb_t  mem_wb_i,
    output riscv_pkg::fwd_sel_t fwd_rs1_o,
    output riscv_pkg::fwd_sel_t fwd_rs2_o
);

    import riscv_pkg::*;

    logic ex_mem_writes;
    logic mem_wb_writes;

    // producers that write a real register
    assign ex_mem_writes = ex_mem_i.write_rd && (ex_mem_i.rd_addr != '0);
    assign mem_wb_writes = mem_wb_i.write_rd && (mem_wb_i.rd_addr != '0);

    // youngest producer wins
    function automatic fwd_sel_t select_src(reg_addr_t rs);
        fwd_sel_t sel;
        if (ex_mem_writes && (ex_mem_i.rd_addr == rs))
            sel = FWD_EX_MEM;
        else if (mem_wb_writes && (mem_wb_i.rd_addr == rs))
            sel = FWD_MEM_WB;
        else
            sel = FWD_NONE;
        return sel;
    endfunction

    always_comb
    begin
        fwd_rs1_o = select_src(id_ex_i.uop.rs1_addr);
        fwd_rs2_o = select_src(id_ex_i.uop.rs2_addr);
    end

endmodule

//--- rtl/execute.sv
// execute stage with forwarding muxes, alu, branch resolution and the EX/MEM register
`include "riscv_config.svh"

module execute
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  riscv_pkg::id_ex_t    id_ex_i,
    input  riscv_pkg::fwd_sel_t  fwd_rs1_i,
    input  riscv_pkg::fwd_sel_t  fwd_rs2_i,
    input  logic [`RV_XLEN-1:0]  ex_mem_fwd_i,
    input  logic [`RV_XLEN-1:0]  mem_wb_fwd_i,
    output riscv_pkg::ex_mem_t   ex_mem_o,
    output riscv_pkg::redirect_t redirect_o
);

    import riscv_pkg::*;

    xlen_t      rs1_data;
    xlen_t      rs2_data;
    xlen_t      operand1;
    xlen_t      operand2;
    xlen_t      alu_result;
    logic [4:0] shamt;

    function automatic xlen_t fwd_mux(fwd_sel_t sel, xlen_t reg_data);
        xlen_t data;
        case (sel)
            FWD_EX_MEM: data = ex_mem_fwd_i;
            FWD_MEM_WB: data = mem_wb_fwd_i;
            default:    data = reg_data;
        endcase
        return data;
    endfunction

    // most recent values of the source registers
    always_comb
    begin
        rs1_data = fwd_mux(fwd_rs1_i, id_ex_i.rs1_data);
        rs2_data = fwd_mux(fwd_rs2_i, id_ex_i.rs2_data);
    end

    always_comb
    begin
        case (id_ex_i.uop.oper1_src)
            OPER1_PC:   operand1 = id_ex_i.uop.pc;
            OPER1_ZERO: operand1 = '0;
            default:    operand1 = rs1_data;
        endcase
    end

    // PC_INC gives the link address for jumps
    always_comb
    begin
        case (id_ex_i.uop.oper2_src)
            OPER2_IMM:    operand2 = id_ex_i.uop.imm;
            OPER2_PC_INC: operand2 = xlen_t'(4);
            default:      operand2 = rs2_data;
        endcase
    end

    assign shamt = operand2[4:0];

    always_comb
    begin
        case (id_ex_i.uop.alu_oper)
            ALU_SUB:  alu_result = operand1 - operand2;
            ALU_SEQ:  alu_result = xlen_t'(operand1 == operand2);
            ALU_SNEQ: alu_result = xlen_t'(operand1 != operand2);
            ALU_SLT:  alu_result = xlen_t'($signed(operand1) < $signed(operand2));
            ALU_SGE:  alu_result = xlen_t'($signed(operand1) >= $signed(operand2));
            ALU_SLTU: alu_result = xlen_t'(operand1 < operand2);
            ALU_SGEU: alu_result = xlen_t'(operand1 >= operand2);
            ALU_XOR:  alu_result = operand1 ^ operand2;
            ALU_OR:   alu_result = operand1 | operand2;
            ALU_AND:  alu_result = operand1 & operand2;
            ALU_SLL:  alu_result = operand1 << shamt;
            ALU_SRL:  alu_result = operand1 >> shamt;
            ALU_SRA:  alu_result = xlen_t'($signed(operand1) >>> shamt);
            default:  alu_result = operand1 + operand2;
        endcase
    end

    // branch condition comes from bit 0 of the compare result
    always_comb
    begin
        redirect_o.load_pc = 1'b0;
        redirect_o.new_pc  = '0;
        if (id_ex_i.valid)
        begin
            case (id_ex_i.uop.bnj_oper)
                BNJ_JAL:
                begin
                    redirect_o.load_pc = 1'b1;
                    redirect_o.new_pc  = id_ex_i.uop.pc + id_ex_i.uop.imm;
                end
                BNJ_JALR:
                begin
                    redirect_o.load_pc = 1'b1;
                    redirect_o.new_pc  = rs1_data + id_ex_i.uop.imm;
                end
                BNJ_BRANCH:
                begin
                    redirect_o.load_pc = alu_result[0];
                    redirect_o.new_pc  = id_ex_i.uop.pc + id_ex_i.uop.imm;
                end
                default:
                begin
                    redirect_o.load_pc = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            ex_mem_o <= '0;
        end
        else
        begin
            ex_mem_o.alu_result <= alu_result;
            ex_mem_o.store_data <= rs2_data;
            ex_mem_o.wb_use_mem <= id_ex_i.uop.wb_use_mem;
            ex_mem_o.rd_addr    <= id_ex_i.uop.rd_addr;
            // invalid entry moves on as a bubble
            ex_mem_o.mem_oper   <= id_ex_i.valid ? id_ex_i.uop.mem_oper : MEM_NOP;
            ex_mem_o.write_rd   <= id_ex_i.valid && id_ex_i.uop.write_rd;
        end
    end

    // the entry behind a redirect was flushed in id_ex_stage
    no_redirect_after_redirect: assert property (@(posedge clk_i) disable iff (!rstn_i)
        redirect_o.load_pc |=> !redirect_o.load_pc)
        else $error("redirect from an instruction that should have been squashed");

endmodule

//--- rtl/mem_stage.sv
// data memory with word and byte access, load extension and the MEM/WB register
`include "riscv_config.svh"

module mem_stage
(
    input  logic                clk_i,
    input  logic                rstn_i,
    input  riscv_pkg::ex_mem_t  ex_mem_i,
    output logic [`RV_XLEN-1:0] fwd_data_o,
    output riscv_pkg::mem_wb_t  mem_wb_o
);

    import riscv_pkg::*;

    localparam int IDX_W = $clog2(`RV_DMEM_WORDS);

    xlen_t            dmem [`RV_DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic [1:0]       byte_lane;
    xlen_t            rd_word;
    logic [7:0]       rd_byte;
    xlen_t            load_data;

    // word address wraps at the memory depth
    assign word_idx  = ex_mem_i.alu_result[2 +: IDX_W];
    assign byte_lane = ex_mem_i.alu_result[1:0];
    assign rd_word   = dmem[word_idx];
    assign rd_byte   = rd_word[{byte_lane, 3'b000} +: 8];

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++)
                dmem[i] <= '0;
        end
        else if (ex_mem_i.mem_oper == MEM_SW)
        begin
            dmem[word_idx] <= ex_mem_i.store_data;
        end
        else if (ex_mem_i.mem_oper == MEM_SB)
        begin
            dmem[word_idx][{byte_lane, 3'b000} +: 8] <= ex_mem_i.store_data[7:0];
        end
    end

    always_comb
    begin
        case (ex_mem_i.mem_oper)
            MEM_LB:  load_data = {{(`RV_XLEN-8){rd_byte[7]}}, rd_byte};
            MEM_LBU: load_data = {{(`RV_XLEN-8){1'b0}}, rd_byte};
            default: load_data = rd_word;
        endcase
    end

    // also feeds EX/MEM forwarding so a load needs no stall
    assign fwd_data_o = ex_mem_i.wb_use_mem ? load_data : ex_mem_i.alu_result;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            mem_wb_o <= '0;
        end
        else
        begin
            mem_wb_o.result   <= fwd_data_o;
            mem_wb_o.write_rd <= ex_mem_i.write_rd;
            mem_wb_o.rd_addr  <= ex_mem_i.rd_addr;
        end
    end

    mem_oper_legal: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ex_mem_i.mem_oper inside {MEM_NOP, MEM_LW, MEM_LB, MEM_LBU, MEM_SW, MEM_SB})
        else $error("illegal memory operation %0d", ex_mem_i.mem_oper);

endmodule

//--- rtl/riscv_backend.sv
// back end top level joining operand read, forwarding, execute and memory stages
`include "riscv_config.svh"

module riscv_backend
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 issue_valid_i,
    input  riscv_pkg::issue_t    issue_i,
    output riscv_pkg::redirect_t redirect_o,
    output logic                 wb_valid_o,
    output riscv_pkg::reg_addr_t wb_rd_o,
    output logic [`RV_XLEN-1:0]  wb_data_o
);

    import riscv_pkg::*;

    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    fwd_sel_t fwd_rs1;
    fwd_sel_t fwd_rs2;
    xlen_t    mem_fwd_data;

    // a redirect squashes the strobe of the same cycle
    id_ex_stage u_id_ex_stage (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .flush_i       (redirect_o.load_pc),
        .wb_i          (mem_wb),
        .id_ex_o       (id_ex)
    );

    forward_unit u_forward_unit (
        .id_ex_i   (id_ex),
        .ex_mem_i  (ex_mem),
        .mem_wb_i  (mem_wb),
        .fwd_rs1_o (fwd_rs1),
        .fwd_rs2_o (fwd_rs2)
    );

    execute u_execute (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .id_ex_i      (id_ex),
        .fwd_rs1_i    (fwd_rs1),
        .fwd_rs2_i    (fwd_rs2),
        .ex_mem_fwd_i (mem_fwd_data),
        .mem_wb_fwd_i (mem_wb.result),
        .ex_mem_o     (ex_mem),
        .redirect_o   (redirect_o)
    );

    mem_stage u_mem_stage (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .ex_mem_i   (ex_mem),
        .fwd_data_o (mem_fwd_data),
        .mem_wb_o   (mem_wb)
    );

    // retire port, writes to x0 are not reported
    assign wb_valid_o = mem_wb.write_rd && (mem_wb.rd_addr != '0);
    assign wb_rd_o    = mem_wb.rd_addr;
    assign wb_data_o  = mem_wb.result;

endmodule

//--- tests/backend_checker.sv
// in-order reference model of the back end, compares retire and redirect ports
`include "riscv_config.svh"

module backend_checker
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 issue_valid_i,
    input  riscv_pkg::issue_t    issue_i,
    input  riscv_pkg::redirect_t redirect_i,
    input  logic                 wb_valid_i,
    input  riscv_pkg::reg_addr_t wb_rd_i,
    input  logic [`RV_XLEN-1:0]  wb_data_i,
    output int                   error_count_o,
    output int                   retire_count_o,
    output int                   redirect_count_o,
    output int                   pending_o
);

    import riscv_pkg::*;

    typedef struct packed {
        reg_addr_t rd;
        xlen_t     data;
    } retire_item_t;

    xlen_t        regs [`RV_NREGS];
    xlen_t        dmem [`RV_DMEM_WORDS];
    retire_item_t expected_q [$];
    redirect_t    exp_redirect;
    logic         squash;

    function automatic xlen_t alu_model(alu_oper_t op, xlen_t a, xlen_t b);
        logic [4:0] sh;
        xlen_t      r;
        sh = b[4:0];
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_SEQ:  r = (a == b) ? 1 : 0;
            ALU_SNEQ: r = (a != b) ? 1 : 0;
            ALU_SLT:  r = ($signed(a) < $signed(b)) ? 1 : 0;
            ALU_SGE:  r = ($signed(a) < $signed(b)) ? 0 : 1;
            ALU_SLTU: r = (a < b) ? 1 : 0;
            ALU_SGEU: r = (a < b) ? 0 : 1;
            ALU_XOR:  r = a ^ b;
            ALU_OR:   r = a | b;
            ALU_AND:  r = a & b;
            ALU_SLL:  r = a << sh;
            ALU_SRL:  r = a >> sh;
            ALU_SRA:  r = xlen_t'($signed(a) >>> sh);
            default:  r = '0;
        endcase
        return r;
    endfunction

    // one instruction in program order, sets the redirect seen next cycle
    task automatic run_uop(issue_t u);
        xlen_t      rs1;
        xlen_t      rs2;
        xlen_t      a;
        xlen_t      b;
        xlen_t      alu;
        xlen_t      result;
        logic [7:0] byte_val;
        int         idx;
        int         lane;
        rs1 = regs[u.rs1_addr];
        rs2 = regs[u.rs2_addr];
        a   = (u.oper1_src == OPER1_PC) ? u.pc : ((u.oper1_src == OPER1_ZERO) ? '0 : rs1);
        b   = (u.oper2_src == OPER2_IMM) ? u.imm : ((u.oper2_src == OPER2_PC_INC) ? 4 : rs2);
        alu = alu_model(u.alu_oper, a, b);
        idx      = (alu >> 2) % `RV_DMEM_WORDS;
        lane     = int'(alu[1:0]);
        byte_val = dmem[idx][lane*8 +: 8];
        case (u.mem_oper)
            MEM_LB:  result = {{(`RV_XLEN-8){byte_val[7]}}, byte_val};
            MEM_LBU: result = {{(`RV_XLEN-8){1'b0}}, byte_val};
            default: result = dmem[idx];
        endcase
        if (!u.wb_use_mem)
            result = alu;
        if (u.mem_oper == MEM_SW)
            dmem[idx] = rs2;
        else if (u.mem_oper == MEM_SB)
            dmem[idx][lane*8 +: 8] = rs2[7:0];
        if (u.write_rd && (u.rd_addr != '0))
        begin
            regs[u.rd_addr] = result;
            expected_q.push_back({u.rd_addr, result});
        end
        case (u.bnj_oper)
            BNJ_JAL:    exp_redirect = {1'b1, u.pc + u.imm};
            BNJ_JALR:   exp_redirect = {1'b1, rs1 + u.imm};
            BNJ_BRANCH: exp_redirect = {alu[0], u.pc + u.imm};
            default:    exp_redirect = '0;
        endcase
    endtask

    task automatic check_redirect();
        if (redirect_i.load_pc !== exp_redirect.load_pc)
        begin
            $display("FAILED redirect_o.load_pc expected %h got %h",
                     exp_redirect.load_pc, redirect_i.load_pc);
            error_count_o++;
        end
        else if (exp_redirect.load_pc && (redirect_i.new_pc !== exp_redirect.new_pc))
        begin
            $display("FAILED redirect_o.new_pc expected %h got %h",
                     exp_redirect.new_pc, redirect_i.new_pc);
            error_count_o++;
        end
        if (exp_redirect.load_pc)
            redirect_count_o++;
    endtask

    task automatic check_retire();
        retire_item_t item;
        if (wb_valid_i !== 1'b1)
            return;
        if (expected_q.size() == 0)
        begin
            $display("retire port reported x%0d but no result was expected", wb_rd_i);
            error_count_o++;
            return;
        end
        item = expected_q.pop_front();
        retire_count_o++;
        if (wb_rd_i !== item.rd)
        begin
            $display("FAILED wb_rd_o expected %h got %h", item.rd, wb_rd_i);
            error_count_o++;
        end
        if (wb_data_i !== item.data)
        begin
            $display("FAILED wb_data_o expected %h got %h", item.data, wb_data_i);
            error_count_o++;
        end
    endtask

    always @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] = '0;
            for (int i = 0; i < `RV_DMEM_WORDS; i++)
                dmem[i] = '0;
            expected_q.delete();
            exp_redirect     = '0;
            error_count_o    = 0;
            retire_count_o   = 0;
            redirect_count_o = 0;
            pending_o        = 0;
        end
        else
        begin
            check_redirect();
            check_retire();
            // a strobe in a redirect cycle is dropped by the front end
            squash       = exp_redirect.load_pc;
            exp_redirect = '0;
            if (issue_valid_i && !squash)
                run_uop(issue_i);
            pending_o = expected_q.size();
        end
    end

endmodule

//--- tests/tb_backend.sv
// testbench top with clock, reset, random micro-op stimulus and timeout
module tb_backend;

    import riscv_pkg::*;

    localparam int NUM_ISSUES = 2000;
    localparam int MAX_CYCLES = 3 * NUM_ISSUES + 50;

    logic      clk;
    logic      rstn;
    logic      issue_valid;
    issue_t    issue;
    redirect_t redirect;
    logic      wb_valid;
    reg_addr_t wb_rd;
    xlen_t     wb_data;
    int        error_count;
    int        retire_count;
    int        redirect_count;
    int        pending;
    integer    seed;
    int        cycles = 0;
    xlen_t     next_pc;

    riscv_backend dut (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .redirect_o    (redirect),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

    backend_checker backend_check (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .issue_valid_i    (issue_valid),
        .issue_i          (issue),
        .redirect_i       (redirect),
        .wb_valid_i       (wb_valid),
        .wb_rd_i          (wb_rd),
        .wb_data_i        (wb_data),
        .error_count_o    (error_count),
        .retire_count_o   (retire_count),
        .redirect_count_o (redirect_count),
        .pending_o        (pending)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // x0 or one of the two address base registers
    function automatic reg_addr_t base_reg();
        int n;
        n = rand_below(3);
        return (n == 0) ? '0 : reg_addr_t'(5 + n);
    endfunction

    task automatic make_uop(output issue_t uop);
        int n;
        uop          = '0;
        uop.pc       = next_pc;
        next_pc      = next_pc + 4;
        uop.rs1_addr = reg_addr_t'(rand_below(8));
        uop.rs2_addr = reg_addr_t'(rand_below(8));
        uop.rd_addr  = reg_addr_t'(rand_below(8));
        uop.imm      = xlen_t'(rand_below(4096)) - xlen_t'(2048);
        uop.write_rd = 1'b1;
        case (rand_below(10))
            0, 1:
                uop.alu_oper = alu_oper_t'(rand_below(14));
            2, 3:
            begin
                uop.oper2_src = OPER2_IMM;
                uop.alu_oper  = alu_oper_t'(rand_below(14));
            end
            4:
            begin
                uop.oper1_src = rand_below(2) ? OPER1_PC : OPER1_ZERO;
                uop.oper2_src = OPER2_IMM;
            end
            5, 9:
            begin
                n              = rand_below(3);
                uop.rs1_addr   = base_reg();
                uop.rd_addr    = reg_addr_t'(rand_below(6));
                uop.imm        = xlen_t'(rand_below(32));
                uop.oper2_src  = OPER2_IMM;
                uop.mem_oper   = (n == 0) ? MEM_LW : ((n == 1) ? MEM_LB : MEM_LBU);
                uop.wb_use_mem = 1'b1;
            end
            6:
            begin
                uop.rs1_addr  = base_reg();
                uop.imm       = xlen_t'(rand_below(32));
                uop.oper2_src = OPER2_IMM;
                uop.mem_oper  = rand_below(2) ? MEM_SW : MEM_SB;
                uop.write_rd  = 1'b0;
            end
            7:
            begin
                uop.alu_oper = alu_oper_t'(ALU_SEQ + rand_below(6));
                uop.bnj_oper = BNJ_BRANCH;
                uop.write_rd = 1'b0;
            end
            default:
            begin
                uop.rd_addr   = reg_addr_t'(rand_below(6));
                uop.oper1_src = OPER1_PC;
                uop.oper2_src = OPER2_PC_INC;
                uop.bnj_oper  = rand_below(2) ? BNJ_JAL : BNJ_JALR;
            end
        endcase
        // x6 and x7 only ever hold small addresses
        if (uop.write_rd && (uop.rd_addr >= 6))
        begin
            uop.oper1_src = OPER1_ZERO;
            uop.oper2_src = OPER2_IMM;
            uop.alu_oper  = ALU_ADD;
            uop.imm       = xlen_t'(rand_below(64) * 4);
        end
    endtask

    task automatic report_counts();
        $display("retired %0d, redirects %0d, errors %0d",
                 retire_count, redirect_count, error_count);
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES)
        begin
            $display("timeout after %0d cycles with %0d results never retired", cycles, pending);
            report_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

    initial
    begin
        seed        = 32'h2cce;
        rstn        = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        next_pc     = 32'h100;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        for (int n = 0; n < NUM_ISSUES; n++)
        begin
            make_uop(issue);
            issue_valid = 1'b1;
            @(negedge clk);
            issue_valid = 1'b0;
            repeat (rand_below(3)) @(negedge clk);
        end
        while (pending != 0)
            @(negedge clk);
        // pipeline depth, any late retire here is an extra one
        repeat (3) @(negedge clk);
        report_counts();
        if (error_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/riscv_pkg.sv
rtl/id_ex_stage.sv
rtl/forward_unit.sv
rtl/execute.sv
rtl/mem_stage.sv
rtl/riscv_backend.sv
tests/backend_checker.sv
tests/tb_backend.sv

//--- Makefile
TOP = tb_backend

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary -j 0 -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf obj_dir
